/* source/forget_gate_pkg.sv */
// Q8.8 signed fixed point throughout, sizes limited to 8 bits (0 to 255 rows and pairs)
`default_nettype none

package forget_gate_pkg;

  ////////////////////
  // Widths

  localparam int FRAC_BITS = 8;  // Q8.8 fraction bits

  typedef logic signed [15:0] fixed_t;  // Q8.8 weight, operand, bias, result
  typedef logic signed [31:0] acc_t;    // Q16.16 product and running sum
  typedef logic [7:0]         size_t;   // Element or pair count

  // Saturation limits of the pre-activation
  localparam fixed_t FIXED_MAX = 16'sh7fff;
  localparam fixed_t FIXED_MIN = 16'sh8000;
  localparam fixed_t FIXED_ONE = 16'sd256;  // 1.0

  ////////////////////
  // Logistic approximation

  // Knees on |x|, Q8.8
  localparam fixed_t SIG_KNEE_1 = 16'sd256;   // 1.0
  localparam fixed_t SIG_KNEE_2 = 16'sd608;   // 2.375
  localparam fixed_t SIG_KNEE_3 = 16'sd1280;  // 5.0

  // Segment offsets, Q8.8
  localparam fixed_t SIG_OFS_0 = 16'sd128;  // 0.5
  localparam fixed_t SIG_OFS_1 = 16'sd160;  // 0.625
  localparam fixed_t SIG_OFS_2 = 16'sd216;  // 0.84375

  ////////////////////
  // Sequencer

  typedef enum logic [1:0] {
    IDLE = 2'd0,  // Wait for START
    ROW  = 2'd1   // Count pairs, wait for bias
  } decode_state_e;

endpackage

`default_nettype wire

/* source/forget_gate_mac_if.sv */
// Decode drives every signal; strobes last one cycle, data is valid only with its strobe
`timescale 1ns/10ps
`default_nettype none

interface forget_gate_mac_if import forget_gate_pkg::*; ();

  // Pair channel
  logic   acc_en;   // One product to accumulate
  fixed_t weight;
  fixed_t operand;

  // Row close
  logic   bias_en;  // Closes the current row
  fixed_t bias;
  logic   row_last; // Final row, or alone for an empty vector

  ////////////////////
  // Views

  modport decode (
    output acc_en,
    output weight,
    output operand,
    output bias_en,
    output bias,
    output row_last
  );

  modport mac (
    input acc_en,
    input weight,
    input operand,
    input bias_en,
    input bias,
    input row_last
  );

endinterface

`default_nettype wire

/* source/forget_gate_decode.sv */
// Single START in IDLE only; extra pairs and early biases are dropped silently, no back-pressure
`timescale 1ns/10ps
`default_nettype none

module forget_gate_decode import forget_gate_pkg::*; (
  input  wire    CLK,
  input  wire    RST,

  input  wire    START,
  input  size_t  SIZE_L_IN,
  input  size_t  SIZE_N_IN,

  input  wire    PAIR_IN_ENABLE,
  input  fixed_t W_IN,
  input  fixed_t V_IN,

  input  wire    B_IN_ENABLE,
  input  fixed_t B_IN,

  forget_gate_mac_if.decode mac
);

  decode_state_e state;

  size_t size_n;     // Pairs per row, latched on START
  size_t pair_cnt;   // Pairs taken in the current row
  size_t rows_left;  // Rows still to close

  logic pair_take;
  logic bias_take;

  ////////////////////
  // Acceptance rules

  // Pair only while the row is short of SIZE_N
  assign pair_take = (state == ROW) && PAIR_IN_ENABLE && (pair_cnt != size_n);
  // Bias only once the row is full
  assign bias_take = (state == ROW) && B_IN_ENABLE && (pair_cnt == size_n);

  ////////////////////
  // FSM and counters

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= IDLE;
      size_n       <= '0;
      pair_cnt     <= '0;
      rows_left    <= '0;
      mac.acc_en   <= 1'b0;
      mac.bias_en  <= 1'b0;
      mac.row_last <= 1'b0;
    end else begin
      // Strobes default low, one cycle each
      mac.acc_en   <= 1'b0;
      mac.bias_en  <= 1'b0;
      mac.row_last <= 1'b0;

      case (state)
        IDLE: begin
          if (START) begin
            size_n    <= SIZE_N_IN;
            rows_left <= SIZE_L_IN;
            pair_cnt  <= '0;
            if (SIZE_L_IN != '0) begin
              state <= ROW;
            end else begin
              mac.row_last <= 1'b1;  // Empty vector, READY with no output
            end
          end
        end

        ROW: begin
          if (pair_take) begin
            mac.acc_en <= 1'b1;
            pair_cnt   <= pair_cnt + size_t'(1);
          end
          if (bias_take) begin
            mac.bias_en <= 1'b1;
            pair_cnt    <= '0;  // Next row may start right away
            rows_left   <= rows_left - size_t'(1);
            if (rows_left == size_t'(1)) begin
              mac.row_last <= 1'b1;
              state        <= IDLE;  // New START one cycle later
            end
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////
  // Payload

  always_ff @(posedge CLK) begin
    if (pair_take) begin
      mac.weight  <= W_IN;
      mac.operand <= V_IN;
    end
    if (bias_take) begin
      mac.bias <= B_IN;
    end
  end

endmodule

`default_nettype wire

/* source/forget_gate_mac.sv */
// Accumulator wraps at 32 bits without warning; only the final Q8.8 result saturates
`timescale 1ns/10ps
`default_nettype none

module forget_gate_mac import forget_gate_pkg::*; (
  input  wire    CLK,
  input  wire    RST,

  forget_gate_mac_if.mac mac,

  output logic   pre_valid,  // One cycle after bias_en
  output fixed_t pre_act,
  output logic   pre_last
);

  acc_t acc_q;    // Running Q16.16 sum of the row
  acc_t product;  // Full-width W*V
  acc_t scaled;   // Sum back in Q8.8 scale
  acc_t pre_sum;  // Scaled sum plus bias, before clamping
  fixed_t pre_sat;

  ////////////////////
  // Datapath

  // Sign-extend before multiplying, product is exact in 32 bits
  assign product = acc_t'(mac.weight) * acc_t'(mac.operand);

  assign scaled  = acc_q >>> FRAC_BITS;          // Arithmetic, truncates toward -inf
  assign pre_sum = scaled + acc_t'(mac.bias);    // No overflow, |scaled| < 2^23

  always_comb begin
    if (pre_sum > acc_t'(FIXED_MAX)) begin
      pre_sat = FIXED_MAX;
    end else if (pre_sum < acc_t'(FIXED_MIN)) begin
      pre_sat = FIXED_MIN;
    end else begin
      pre_sat = fixed_t'(pre_sum);  // In range, low half is exact
    end
  end

  ////////////////////
  // Accumulator and row close

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc_q     <= '0;
      pre_valid <= 1'b0;
      pre_last  <= 1'b0;
    end else begin
      pre_valid <= mac.bias_en;
      pre_last  <= mac.row_last;  // Also passes the empty-vector marker
      if (mac.bias_en) begin
        acc_q <= '0;  // Next pair starts a fresh row
      end else if (mac.acc_en) begin
        acc_q <= acc_q + product;  // Wraparound
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (mac.bias_en) begin
      pre_act <= pre_sat;
    end
  end

endmodule

`default_nettype wire

/* source/forget_gate_sigmoid.sv */
// Four-segment logistic, error up to about 0.02; READY follows pre_last even with no output
`timescale 1ns/10ps
`default_nettype none

module forget_gate_sigmoid import forget_gate_pkg::*; (
  input  wire    CLK,
  input  wire    RST,

  input  wire    pre_valid,
  input  wire    pre_last,
  input  fixed_t pre_act,

  output logic   F_OUT_ENABLE,
  output logic   READY,
  output fixed_t F_OUT
);

  logic [15:0] mag;    // |pre_act|, unsigned so -32768 fits
  logic [15:0] y_pos;  // Logistic of |x|, at most 1.0
  fixed_t      y;

  ////////////////////
  // Piecewise-linear logistic

  // Two's complement negate, 0x8000 reads as 32768 unsigned
  assign mag = pre_act[15] ? 16'(-pre_act) : 16'(pre_act);

  always_comb begin
    if (mag >= 16'(SIG_KNEE_3)) begin
      y_pos = 16'(FIXED_ONE);  // Flat top
    end else if (mag >= 16'(SIG_KNEE_2)) begin
      y_pos = (mag >> 5) + 16'(SIG_OFS_2);  // Slope 1/32
    end else if (mag >= 16'(SIG_KNEE_1)) begin
      y_pos = (mag >> 3) + 16'(SIG_OFS_1);  // Slope 1/8
    end else begin
      y_pos = (mag >> 2) + 16'(SIG_OFS_0);  // Slope 1/4 around zero
    end
  end

  // Symmetry, sigmoid(-x) = 1 - sigmoid(x)
  assign y = pre_act[15] ? (FIXED_ONE - fixed_t'(y_pos)) : fixed_t'(y_pos);

  ////////////////////
  // Output stage

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      F_OUT_ENABLE <= 1'b0;
      READY        <= 1'b0;
      F_OUT        <= '0;
    end else begin
      F_OUT_ENABLE <= pre_valid;
      READY        <= pre_last;  // Same cycle as last F_OUT_ENABLE
      if (pre_valid) begin
        F_OUT <= y;  // Held until the next element
      end
    end
  end

endmodule

`default_nettype wire

/* source/forget_gate_vector.sv */
// Bias to F_OUT_ENABLE is two cycles, at most two rows in flight, no back-pressure on any input
`timescale 1ns/10ps
`default_nettype none

module forget_gate_vector import forget_gate_pkg::*; (
  input  wire    CLK,
  input  wire    RST,

  // Control
  input  wire    START,
  output logic   READY,   // With the last F_OUT_ENABLE

  input  size_t  SIZE_L_IN,  // Elements in the vector
  input  size_t  SIZE_N_IN,  // Pairs per element

  // Pair stream, W*x, K*r and U*h back to back
  input  wire    PAIR_IN_ENABLE,
  input  fixed_t W_IN,
  input  fixed_t V_IN,

  // Row bias
  input  wire    B_IN_ENABLE,
  input  fixed_t B_IN,

  // Result
  output logic   F_OUT_ENABLE,
  output fixed_t F_OUT
);

  // Execute to result
  logic   pre_valid;
  logic   pre_last;
  fixed_t pre_act;

  forget_gate_mac_if mac_if ();

  ////////////////////
  // Decode

  forget_gate_decode decode_i (
    .CLK           (CLK),
    .RST           (RST),
    .START         (START),
    .SIZE_L_IN     (SIZE_L_IN),
    .SIZE_N_IN     (SIZE_N_IN),
    .PAIR_IN_ENABLE(PAIR_IN_ENABLE),
    .W_IN          (W_IN),
    .V_IN          (V_IN),
    .B_IN_ENABLE   (B_IN_ENABLE),
    .B_IN          (B_IN),
    .mac           (mac_if.decode)
  );

  ////////////////////
  // Execute

  forget_gate_mac mac_i (
    .CLK      (CLK),
    .RST      (RST),
    .mac      (mac_if.mac),
    .pre_valid(pre_valid),
    .pre_act  (pre_act),
    .pre_last (pre_last)
  );

  ////////////////////
  // Result

  forget_gate_sigmoid sigmoid_i (
    .CLK         (CLK),
    .RST         (RST),
    .pre_valid   (pre_valid),
    .pre_last    (pre_last),
    .pre_act     (pre_act),
    .F_OUT_ENABLE(F_OUT_ENABLE),
    .READY       (READY),
    .F_OUT       (F_OUT)
  );

endmodule

`default_nettype wire

/* dv/forget_gate_assertions.sv */
// Port-level checks only; an empty vector (SIZE_L_IN of 0) would trip the READY rule
`timescale 1ns/10ps
`default_nettype none

module forget_gate_assertions (
  input wire CLK,
  input wire RST,
  input wire B_IN_ENABLE,
  input wire F_OUT_ENABLE,
  input wire READY
);

  ////////////////////
  // Output timing

  // Bias sampled at edge t, output sampled at edge t+3
  a_fout_after_bias : assert property (
    @(posedge CLK) disable iff (RST) F_OUT_ENABLE |-> $past(B_IN_ENABLE, 3)
  ) else $error("F_OUT_ENABLE without a bias three samples earlier");

  a_ready_with_fout : assert property (
    @(posedge CLK) disable iff (RST) READY |-> F_OUT_ENABLE  // Last element only
  ) else $error("READY without F_OUT_ENABLE");

  ////////////////////
  // Reset

  a_quiet_in_reset : assert property (
    @(posedge CLK) RST |-> (!F_OUT_ENABLE && !READY)
  ) else $error("Output strobe high during reset");

endmodule

bind forget_gate_vector forget_gate_assertions assertions_i (
  .CLK         (CLK),
  .RST         (RST),
  .B_IN_ENABLE (B_IN_ENABLE),
  .F_OUT_ENABLE(F_OUT_ENABLE),
  .READY       (READY)
);

`default_nettype wire

/* dv/forget_gate_tb.sv */
// Directed tests with a cycle-level model; stops at the first mismatch, SIZE_L_IN of 0 not covered
`timescale 1ns/10ps
`default_nettype none

module forget_gate_tb import forget_gate_pkg::*; ();

  logic   CLK;
  logic   RST;
  logic   START;
  size_t  SIZE_L_IN;
  size_t  SIZE_N_IN;
  logic   PAIR_IN_ENABLE;
  fixed_t W_IN;
  fixed_t V_IN;
  logic   B_IN_ENABLE;
  fixed_t B_IN;
  logic   F_OUT_ENABLE;
  fixed_t F_OUT;
  logic   READY;

  // Model of the accepted sequence
  logic   m_busy;
  size_t  m_n;
  size_t  m_rows;
  size_t  m_pairs;
  acc_t   m_acc;
  int     cycle;        // Counted at each falling edge
  fixed_t exp_val[$];   // Expected F_OUT in order
  int     exp_cycle[$]; // Falling-edge count that sees F_OUT_ENABLE
  logic   exp_last[$];  // READY expected with this element

  forget_gate_vector forget_gate_vector_i (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;  // 4 ns
  end

  ////////////////////
  // Helpers

  task automatic step();
    @(posedge CLK);
    #1;  // Drive and sample clear of the edge
  endtask

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_fixed(input string name, input fixed_t got, input fixed_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("ERR %s got 0x%04h expected 0x%04h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("ERR %s got 0x%01h expected 0x%01h", name, got, exp));
    end
  endtask

  // Rescale, add bias, clamp to 16 bits
  function automatic fixed_t expected_pre(input acc_t acc, input fixed_t b);
    longint s;
    s = (longint'(acc) >>> 8) + longint'(b);
    if (s > 32767) s = 32767;
    if (s < -32768) s = -32768;
    return fixed_t'(s);
  endfunction

  // Four segments on |x| mirrored for negative x
  function automatic fixed_t logistic_ref(input fixed_t x);
    int a;
    int y;
    a = (x < 0) ? -int'(x) : int'(x);
    if (a >= 1280) y = 256;
    else if (a >= 608) y = a / 32 + 216;
    else if (a >= 256) y = a / 8 + 160;
    else y = a / 4 + 128;
    if (x < 0) y = 256 - y;
    return fixed_t'(y);
  endfunction

  ////////////////////
  // Drivers of one cycle each

  task automatic send_start(input size_t l, input size_t n);
    START = 1'b1;
    SIZE_L_IN = l;
    SIZE_N_IN = n;
    step();
    START = 1'b0;
    if (!m_busy) begin  // Ignored mid-vector
      m_n = n;
      m_rows = l;
      m_pairs = '0;
      m_acc = '0;
      m_busy = (l != 0);
    end
  endtask

  task automatic send_pair(input fixed_t w, input fixed_t v);
    PAIR_IN_ENABLE = 1'b1;
    W_IN = w;
    V_IN = v;
    step();
    PAIR_IN_ENABLE = 1'b0;
    if (m_busy && m_pairs != m_n) begin
      m_acc = acc_t'(longint'(m_acc) + longint'(w) * longint'(v));  // Wraps at 32 bits
      m_pairs++;
    end
  endtask

  task automatic send_bias(input fixed_t b);
    B_IN_ENABLE = 1'b1;
    B_IN = b;
    step();
    B_IN_ENABLE = 1'b0;
    if (m_busy && m_pairs == m_n) begin  // Early bias dropped
      m_rows--;
      exp_val.push_back(logistic_ref(expected_pre(m_acc, b)));
      exp_cycle.push_back(cycle + 3);  // Two rising edges after the bias edge
      exp_last.push_back(m_rows == 0);
      m_acc = '0;
      m_pairs = '0;
      if (m_rows == 0) m_busy = 1'b0;
    end
  endtask

  task automatic wait_outputs();
    int waited;
    waited = 0;
    while (exp_val.size() != 0) begin
      step();
      waited++;
      if (waited > 20) stop_with_error("Timeout waiting for F_OUT_ENABLE");
    end
  endtask

  function automatic fixed_t rand_fixed(input int span);
    return fixed_t'(int'($urandom % span) - span / 2);  // Centred on zero
  endfunction

  ////////////////////
  // Output monitor

  always @(negedge CLK) begin
    cycle++;
    if (!RST) begin
      if (F_OUT_ENABLE) begin
        if (exp_val.size() == 0) begin
          stop_with_error("F_OUT_ENABLE pulsed with no accepted bias");
        end else begin
          if (cycle != exp_cycle[0]) begin
            stop_with_error($sformatf("F_OUT_ENABLE at cycle %0d, expected at cycle %0d",
                                      cycle, exp_cycle[0]));
          end
          check_fixed("F_OUT", F_OUT, exp_val.pop_front());
          check_flag("READY", READY, exp_last.pop_front());
          void'(exp_cycle.pop_front());
        end
      end else begin
        check_flag("READY", READY, 1'b0);  // Never alone
      end
    end
  end

  ////////////////////
  // Tests

  task automatic reset_state();
    repeat (10) begin
      step();
      check_flag("READY", READY, 1'b0);
      check_flag("F_OUT_ENABLE", F_OUT_ENABLE, 1'b0);
      check_fixed("F_OUT", F_OUT, 16'sd0);
    end
  endtask

  task automatic sweep_regions();
    fixed_t ops[$];
    ops = '{16'sd0, 16'sd100, -16'sd100, 16'sd255, 16'sd256, -16'sd256, 16'sd400,
            16'sd607, 16'sd608, -16'sd608, 16'sd1000, 16'sd1279, 16'sd1280,
            -16'sd1280, 16'sd2000, 16'sh7fff, 16'sh8000, -16'sd1, 16'sd1};
    foreach (ops[i]) begin
      send_start(8'd1, 8'd1);
      send_pair(FIXED_ONE, ops[i]);  // Pre-activation equals the operand
      send_bias(16'sd0);
      wait_outputs();
    end
  endtask

  task automatic multi_row_vector();
    send_start(8'd5, 8'd6);
    for (int r = 0; r < 5; r++) begin
      for (int p = 0; p < 6; p++) begin
        send_pair(rand_fixed(512), rand_fixed(1024));  // Weight within 1.0 and operand 2.0
      end
      send_bias(rand_fixed(1024));  // Next row follows at once
    end
    wait_outputs();
  endtask

  task automatic accumulator_saturation();
    send_start(8'd2, 8'd2);
    send_pair(16'sh7fff, 16'sh7fff);
    send_pair(16'sh7fff, 16'sh7fff);
    send_bias(16'sd0);   // Clamps high for an output of 1.0
    send_pair(16'sh7fff, 16'sh8000);
    send_pair(16'sh7fff, 16'sh8000);
    send_bias(16'sd0);   // Clamps low for an output of 0
    wait_outputs();
    check_fixed("F_OUT", F_OUT, 16'sd0);  // Held after the last pulse
  endtask

  task automatic acceptance_rules();
    send_pair(16'sd300, 16'sd300);   // Idle strobes
    send_bias(16'sd50);
    repeat (4) step();
    send_start(8'd2, 8'd2);
    send_bias(16'sd77);              // Early
    send_pair(16'sd256, 16'sd200);
    send_pair(-16'sd128, 16'sd90);
    send_pair(16'sd512, 16'sd512);   // Beyond SIZE_N
    send_bias(16'sd40);
    send_start(8'd3, 8'd1);          // Busy
    send_pair(16'sd64, -16'sd700);
    send_bias(-16'sd30);             // Early by one pair
    send_pair(16'sd256, 16'sd100);
    send_bias(-16'sd30);
    wait_outputs();
  endtask

  task automatic zero_pair_rows();
    send_start(8'd3, 8'd0);
    send_bias(16'sd700);   // Sigmoid of the bias alone
    send_bias(-16'sd300);
    send_bias(16'sd10);
    wait_outputs();
  endtask

  ////////////////////
  // Sequence

  initial begin
    void'($urandom(18730));
    RST = 1'b1;
    START = 1'b0;
    SIZE_L_IN = '0;
    SIZE_N_IN = '0;
    PAIR_IN_ENABLE = 1'b0;
    W_IN = '0;
    V_IN = '0;
    B_IN_ENABLE = 1'b0;
    B_IN = '0;
    m_busy = 1'b0;
    m_n = '0;
    m_rows = '0;
    m_pairs = '0;
    m_acc = '0;
    cycle = 0;
    step();
    step();
    RST = 1'b0;  // Two cycles held

    reset_state();
    sweep_regions();
    multi_row_vector();
    accumulator_saturation();
    acceptance_rules();
    zero_pair_rows();
    repeat (5) step();  // Catch any late stray output

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
source/forget_gate_pkg.sv
source/forget_gate_mac_if.sv
source/forget_gate_decode.sv
source/forget_gate_mac.sv
source/forget_gate_sigmoid.sv
source/forget_gate_vector.sv
dv/forget_gate_assertions.sv
dv/forget_gate_tb.sv

/* Bender.yml */
package:
  name: forget_gate

sources:
  - source/forget_gate_pkg.sv
  - source/forget_gate_mac_if.sv
  - source/forget_gate_decode.sv
  - source/forget_gate_mac.sv
  - source/forget_gate_sigmoid.sv
  - source/forget_gate_vector.sv
  - target: test
    files:
      - dv/forget_gate_assertions.sv
      - dv/forget_gate_tb.sv
